// File: compile.f
+incdir+.
u2_pkg.sv
settings_bus.sv
setting_reg_bank.sv
vita_time_64.sv
status_readback.sv
ctrl_pins.sv
u2_control_core.sv
tb_u2_control_core.sv

// File: ctrl_pins.sv
//////////////////////////////////////////////////////////////////////
// Registered control pins and LED source mix
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_pins (
   input  logic               dsp_clk,
   input  logic               wb_rst,
   input  u2_pkg::ctrl_regs_t regs_i,
   input  logic               clk_status_i,
   input  logic               serdes_link_up_i,
   output logic [7:0]         leds_o,
   output logic               clock_ready_o,
   output logic [1:0]         clk_en_o,
   output logic [1:0]         clk_sel_o,
   output logic               ser_enable_o,
   output logic               ser_prbsen_o,
   output logic               ser_loopen_o,
   output logic               ser_rx_en_o,
   output logic               adc_oe_a_o,
   output logic               adc_on_a_o,
   output logic               adc_oe_b_o,
   output logic               adc_on_b_o,
   output logic               phy_resetn_o
);

   logic [7:0] led_hw;

   // Hardware status LEDs, upper bits unused
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         leds_o         <= '0;
         {clock_ready_o, clk_en_o, clk_sel_o} <= '0;
         {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} <= '0;
         {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} <= '0;
         // PHY held out of reset
         phy_resetn_o   <= 1'b1;
      end else begin
         // Clock generator, highest bit first
         {clock_ready_o, clk_en_o, clk_sel_o} <= regs_i.clock_outs[4:0];
         {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} <= regs_i.serdes_outs[3:0];
         {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} <= regs_i.adc_outs[3:0];
         phy_resetn_o   <= ~regs_i.phy_reset;
         // Source bit 1 picks hardware
         leds_o         <= (regs_i.led_src & led_hw) | (~regs_i.led_src & regs_i.led_sw);
      end
   end

endmodule

// File: setting_reg_bank.sv
//////////////////////////////////////////////////////////////////////
// Control setting registers written over the settings bus
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_params.svh"

module setting_reg_bank (
   input  logic               dsp_clk,
   input  logic               wb_rst,
   input  u2_pkg::set_bus_t   set_i,
   output u2_pkg::ctrl_regs_t regs_o
);
   import u2_pkg::*;

   ctrl_regs_t regs_q;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         regs_q <= '0;
      end else if (set_i.stb) begin
         // Each setting keeps only its field width
         case (set_i.addr)
            `U2_SR_CLOCK: begin
               regs_q.clock_outs <= set_i.data[7:0];
            end
            `U2_SR_SERDES: begin
               regs_q.serdes_outs <= set_i.data[7:0];
            end
            `U2_SR_ADC: begin
               regs_q.adc_outs <= set_i.data[7:0];
            end
            `U2_SR_LED_SW: begin
               regs_q.led_sw <= set_i.data[7:0];
            end
            `U2_SR_PHY: begin
               regs_q.phy_reset <= set_i.data[0];
            end
            // 1 selects hardware status for that LED
            `U2_SR_LED_SRC: begin
               regs_q.led_src <= set_i.data[7:0];
            end
            `U2_SR_IRQ_MASK: begin
               regs_q.irq_mask <= set_i.data[`U2_NIRQ-1:0];
            end
            // Addresses of other blocks
            default: begin
            end
         endcase
      end
   end

   assign regs_o = regs_q;

   // Settings only move on a strobe
   a_regs_stable : assert property (@(posedge dsp_clk) disable iff (wb_rst)
      !set_i.stb |=> $stable(regs_o));

endmodule

// File: settings_bus.sv
//////////////////////////////////////////////////////////////////////
// Bus slave that turns writes into settings strobes
// Reads go to the readback stage and are acked with its word
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_params.svh"

module settings_bus (
   input  logic             dsp_clk,
   input  logic             wb_rst,
   input  u2_pkg::wb_req_t  wb_req_i,
   input  u2_pkg::wb_word_t rd_dat_i,
   output logic             wb_ack_o,
   output u2_pkg::wb_word_t wb_dat_o,
   output u2_pkg::set_bus_t set_o,
   output logic             rd_stb_o,
   output logic [3:0]       rd_sel_o
);
   import u2_pkg::*;

   localparam wb_addr_t SET_BASE = `U2_SETTINGS_BASE;
   localparam wb_addr_t RB_BASE  = `U2_READBACK_BASE;

   logic      start;
   logic      in_set;
   logic      rb_read;
   logic      rd_pend;
   logic      rd_ack;
   logic      set_stb_q;
   set_addr_t set_addr_q;
   wb_word_t  set_data_q;

   // New access only when nothing is in flight
   assign start   = wb_req_i.stb & ~wb_ack_o & ~rd_pend;
   assign in_set  = wb_req_i.adr[15:10] == SET_BASE[15:10];
   assign rb_read = ~wb_req_i.we & (wb_req_i.adr[15:10] == RB_BASE[15:10]);

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         wb_ack_o  <= 1'b0;
         rd_pend   <= 1'b0;
         rd_ack    <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         // Readback waits one cycle for the word
         rd_pend   <= start & rb_read;
         wb_ack_o  <= (start & ~rb_read) | rd_pend;
         rd_ack    <= rd_pend;
         set_stb_q <= start & wb_req_i.we & in_set;
      end
   end

   // Address and data captured with the access
   always_ff @(posedge dsp_clk) begin
      if (start) begin
         set_addr_q <= wb_req_i.adr[9:2];
         set_data_q <= wb_req_i.dat;
         rd_sel_o   <= wb_req_i.adr[5:2];
      end
   end

   assign set_o    = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};
   assign rd_stb_o = rd_pend;
   // Zero unless this ack closes a readback
   assign wb_dat_o = rd_ack ? rd_dat_i : '0;

   // Non-read acks are single cycle pulses
   a_single_ack : assert property (@(posedge dsp_clk) disable iff (wb_rst)
      (wb_ack_o && !rd_ack) |=> !wb_ack_o);

endmodule

// File: status_readback.sv
//////////////////////////////////////////////////////////////////////
// Readback word mux with cycle counter and interrupt status
// Word is registered on the read strobe
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_params.svh"

module status_readback (
   input  logic               dsp_clk,
   input  logic               wb_rst,
   input  logic               rd_stb_i,
   input  logic [3:0]         rd_sel_i,
   input  u2_pkg::irq_vec_t   irq_i,
   input  u2_pkg::irq_vec_t   irq_mask_i,
   input  u2_pkg::vita_time_t time_i,
   output u2_pkg::wb_word_t   rd_dat_o,
   output logic               int_o
);
   import u2_pkg::*;

   wb_word_t cycle_count;
   wb_word_t irq_prio;
   wb_word_t rd_word;

   // Free running cycle counter
   always_ff @(posedge dsp_clk) begin
      if (wb_rst)
         cycle_count <= '0;
      else
         cycle_count <= cycle_count + 1'b1;
   end

   ////////////////////////////////////////////////////////////////////
   // Priority encoder
   // Lowest set bit wins, NIRQ when idle
   always_comb begin
      irq_prio = `U2_NIRQ;
      for (int i = `U2_NIRQ - 1; i >= 0; i--) begin
         if (irq_i[i])
            irq_prio = i;
      end
   end

   // Masked interrupt request
   always_ff @(posedge dsp_clk) begin
      if (wb_rst)
         int_o <= 1'b0;
      else
         int_o <= |(irq_i & irq_mask_i);
   end

   ////////////////////////////////////////////////////////////////////
   // Word select
   always_comb begin
      case (rd_sel_i)
         `U2_RB_SECS:     rd_word = time_i.secs;
         `U2_RB_TICKS:    rd_word = time_i.ticks;
         `U2_RB_IRQ:      rd_word = wb_word_t'(irq_i);
         `U2_RB_IRQ_PRIO: rd_word = irq_prio;
         `U2_RB_CYCLES:   rd_word = cycle_count;
         default:         rd_word = '0;
      endcase
   end

   // Held until the next read
   always_ff @(posedge dsp_clk) begin
      if (rd_stb_i)
         rd_dat_o <= rd_word;
   end

endmodule

// File: tb_u2_control_core.sv
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the control core
// Table of pin, LED and interrupt cases, then VITA time and cycle count
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_params.svh"

module tb_u2_control_core;
   import u2_pkg::*;

   localparam int NUM_ENTRIES = 8;
   localparam int MAX_CYCLES  = NUM_ENTRIES * 40 + 500;
   localparam int TPS         = `U2_TICKS_PER_SEC;

   // Pin groups, highest bit first as on the DUT
   typedef struct packed {
      logic [7:0] leds;
      logic [4:0] clk;
      logic [3:0] ser;
      logic [3:0] adc;
      logic       phy_resetn;
   } pins_t;

   // Words for clock, serdes, adc, phy, led_sw, led_src, irq_mask
   typedef struct packed {
      wb_word_t [6:0] data;
      logic [1:0]     hw;
      irq_vec_t       irq;
      pins_t          exp_pins;
      logic           exp_int;
      wb_word_t       exp_prio;
   } entry_t;

   logic        dsp_clk;
   logic        wb_rst;
   wb_req_t     wb_req_i;
   logic        pps_i;
   irq_vec_t    irq_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic        wb_ack_o;
   wb_word_t    wb_dat_o;
   logic        int_o;
   logic [7:0]  leds_o;
   logic        clock_ready_o;
   logic [1:0]  clk_en_o;
   logic [1:0]  clk_sel_o;
   logic        ser_enable_o;
   logic        ser_prbsen_o;
   logic        ser_loopen_o;
   logic        ser_rx_en_o;
   logic        adc_oe_a_o;
   logic        adc_on_a_o;
   logic        adc_oe_b_o;
   logic        adc_on_b_o;
   logic        phy_resetn_o;

   entry_t      stim [NUM_ENTRIES];
   integer      seed = 69313;
   int unsigned cycle_cnt = 0;
   int unsigned ack_cycle;

   u2_control_core u2_control_core_i (.*);

   initial dsp_clk = 1'b0;
   always #20 dsp_clk = ~dsp_clk;

   // Run limit scales with the table
   always @(posedge dsp_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Reference rules
   function automatic set_addr_t reg_addr(input int k);
      case (k)
         0: return `U2_SR_CLOCK;
         1: return `U2_SR_SERDES;
         2: return `U2_SR_ADC;
         3: return `U2_SR_PHY;
         4: return `U2_SR_LED_SW;
         5: return `U2_SR_LED_SRC;
         default: return `U2_SR_IRQ_MASK;
      endcase
   endfunction

   function automatic pins_t expect_pins(input entry_t e);
      pins_t      p;
      logic [7:0] hw_vec;
      // Bit 1 clock status, bit 0 link up
      hw_vec       = {6'b0, e.hw};
      p.clk        = e.data[0][4:0];
      p.ser        = e.data[1][3:0];
      p.adc        = e.data[2][3:0];
      p.phy_resetn = ~e.data[3][0];
      for (int b = 0; b < 8; b++)
         p.leds[b] = e.data[5][b] ? hw_vec[b] : e.data[4][b];
      return p;
   endfunction

   // Lowest set bit, NIRQ when idle
   function automatic wb_word_t expect_prio(input irq_vec_t v);
      for (int b = 0; b < `U2_NIRQ; b++)
         if (v[b])
            return b;
      return `U2_NIRQ;
   endfunction

   // Any source that its mask bit lets through
   function automatic logic expect_int(input irq_vec_t irq, input irq_vec_t mask);
      for (int b = 0; b < `U2_NIRQ; b++)
         if (irq[b] && mask[b])
            return 1'b1;
      return 1'b0;
   endfunction

   function automatic pins_t pins_now();
      return '{leds: leds_o,
               clk: {clock_ready_o, clk_en_o, clk_sel_o},
               ser: {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o},
               adc: {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o},
               phy_resetn: phy_resetn_o};
   endfunction

   ////////////////////////////////////////////////////////////////////
   // Compare tasks
   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_word(input wb_word_t got, input wb_word_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_range(input wb_word_t got, input wb_word_t lo, input wb_word_t hi,
                              input string what);
      if (got < lo || got > hi) begin
         $display("FAILED at %0t: %s is %0d, outside %0d..%0d", $time, what, got, lo, hi);
         abort_run();
      end
   endtask

   task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_pins(input pins_t got, input pins_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s are %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Bus accesses, stb held until ack
   task automatic bus_access(input logic is_write, input wb_addr_t adr, input wb_word_t dat,
                             output wb_word_t rdat);
      @(negedge dsp_clk);
      wb_req_i = '{stb: 1'b1, we: is_write, adr: adr, dat: dat};
      do
         @(negedge dsp_clk);
      while (!wb_ack_o);
      rdat      = wb_dat_o;
      ack_cycle = cycle_cnt;
      wb_req_i  = '0;
   endtask

   task automatic set_write(input set_addr_t sa, input wb_word_t dat);
      wb_word_t ignored;
      bus_access(1'b1, `U2_SETTINGS_BASE | {sa, 2'b00}, dat, ignored);
   endtask

   task automatic rb_read(input logic [3:0] idx, output wb_word_t rdat);
      bus_access(1'b0, `U2_READBACK_BASE | {idx, 2'b00}, '0, rdat);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      wb_word_t    rd;
      wb_word_t    rd2;
      int unsigned first_ack;
      int          gap;
      wb_rst           = 1'b1;
      wb_req_i         = '0;
      pps_i            = 1'b0;
      irq_i            = '0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;

      // Random words, corners on the first two entries
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         for (int k = 0; k < 7; k++)
            stim[i].data[k] = (i == 0) ? '1 : $random(seed);
         stim[i].hw  = $random(seed);
         stim[i].irq = $random(seed);
      end
      stim[0].irq = '0;
      stim[1].irq = 16'h8000;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         stim[i].exp_pins = expect_pins(stim[i]);
         stim[i].exp_int  = expect_int(stim[i].irq, stim[i].data[6][`U2_NIRQ-1:0]);
         stim[i].exp_prio = expect_prio(stim[i].irq);
      end

      repeat (3) @(negedge dsp_clk);
      wb_rst = 1'b0;
      @(negedge dsp_clk);

      // Reset defaults
      check_pins(pins_now(), '{leds: '0, clk: '0, ser: '0, adc: '0, phy_resetn: 1'b1},
                 "reset pins");
      check_flag(int_o, 1'b0, "reset int_o");
      rb_read(`U2_RB_SECS, rd);
      check_word(rd, '0, "reset secs");
      rb_read(`U2_RB_TICKS, rd);
      check_range(rd, 0, 50, "reset ticks");

      // Control split, LED mix and interrupts per entry
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         @(negedge dsp_clk);
         irq_i                           = stim[i].irq;
         {clk_status_i, serdes_link_up_i} = stim[i].hw;
         for (int k = 0; k < 7; k++)
            set_write(reg_addr(k), stim[i].data[k]);
         repeat (3) @(negedge dsp_clk);
         check_pins(pins_now(), stim[i].exp_pins, $sformatf("entry %0d pins", i));
         check_flag(int_o, stim[i].exp_int, $sformatf("entry %0d int_o", i));
         rb_read(`U2_RB_IRQ, rd);
         check_irq(rd[15:0], stim[i].irq, $sformatf("entry %0d irq word", i));
         check_word(rd & 32'hFFFF_0000, '0, $sformatf("entry %0d irq upper bits", i));
         rb_read(`U2_RB_IRQ_PRIO, rd);
         check_word(rd, stim[i].exp_prio, $sformatf("entry %0d irq priority", i));
      end

      // Immediate time set
      set_write(`U2_SR_TIME64, 32'h1234_5678);
      set_write(`U2_SR_TIME64 + 2, 32'd1);
      set_write(`U2_SR_TIME64 + 1, 32'd1000);
      rb_read(`U2_RB_SECS, rd);
      check_word(rd, 32'h1234_5678, "immediate secs");
      rb_read(`U2_RB_TICKS, rd);
      check_range(rd, 1000, 1050, "immediate ticks");

      // Load near the end of a second so secs rolls over
      set_write(`U2_SR_TIME64 + 1, 32'(TPS - 10));
      repeat (20) @(negedge dsp_clk);
      rb_read(`U2_RB_SECS, rd);
      check_word(rd, 32'h1234_5679, "secs after rollover");

      // Timed set waits for PPS
      set_write(`U2_SR_TIME64 + 2, 32'd0);
      set_write(`U2_SR_TIME64, 32'hCAFE_0001);
      set_write(`U2_SR_TIME64 + 1, 32'd5);
      repeat (10) @(negedge dsp_clk);
      rb_read(`U2_RB_SECS, rd);
      check_word(rd, 32'h1234_5679, "secs while armed");
      pps_i = 1'b1;
      repeat (3) @(negedge dsp_clk);
      pps_i = 1'b0;
      repeat (5) @(negedge dsp_clk);
      rb_read(`U2_RB_SECS, rd);
      check_word(rd, 32'hCAFE_0001, "secs after PPS");
      rb_read(`U2_RB_TICKS, rd);
      check_range(rd, 5, 55, "ticks after PPS");

      // Cycle counter delta matches strobe spacing
      rb_read(`U2_RB_CYCLES, rd);
      first_ack = ack_cycle;
      gap       = 3 + ($random(seed) & 7);
      repeat (gap) @(negedge dsp_clk);
      rb_read(`U2_RB_CYCLES, rd2);
      check_word(rd2 - rd, wb_word_t'(ack_cycle - first_ack), "cycle count delta");

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: u2_control_core.sv
//////////////////////////////////////////////////////////////////////
// Control plane top level
// Bus slave, setting registers, time keeper, readback and pins
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module u2_control_core (
   input  logic             dsp_clk,
   input  logic             wb_rst,
   input  u2_pkg::wb_req_t  wb_req_i,
   input  logic             pps_i,
   input  u2_pkg::irq_vec_t irq_i,
   input  logic             clk_status_i,
   input  logic             serdes_link_up_i,
   output logic             wb_ack_o,
   output u2_pkg::wb_word_t wb_dat_o,
   output logic             int_o,
   output logic [7:0]       leds_o,
   output logic             clock_ready_o,
   output logic [1:0]       clk_en_o,
   output logic [1:0]       clk_sel_o,
   output logic             ser_enable_o,
   output logic             ser_prbsen_o,
   output logic             ser_loopen_o,
   output logic             ser_rx_en_o,
   output logic             adc_oe_a_o,
   output logic             adc_on_a_o,
   output logic             adc_oe_b_o,
   output logic             adc_on_b_o,
   output logic             phy_resetn_o
);
   import u2_pkg::*;

   set_bus_t   set_bus;
   ctrl_regs_t ctrl_regs;
   vita_time_t vita_time;
   wb_word_t   rd_dat;
   logic       rd_stb;
   logic [3:0] rd_sel;

   ////////////////////////////////////////////////////////////////////
   // Bus access
   settings_bus settings_bus_i (
      .dsp_clk (dsp_clk),
      .wb_rst  (wb_rst),
      .wb_req_i(wb_req_i),
      .rd_dat_i(rd_dat),
      .wb_ack_o(wb_ack_o),
      .wb_dat_o(wb_dat_o),
      .set_o   (set_bus),
      .rd_stb_o(rd_stb),
      .rd_sel_o(rd_sel)
   );

   ////////////////////////////////////////////////////////////////////
   // Register state
   setting_reg_bank setting_reg_bank_i (
      .dsp_clk(dsp_clk),
      .wb_rst (wb_rst),
      .set_i  (set_bus),
      .regs_o (ctrl_regs)
   );

   vita_time_64 vita_time_64_i (
      .dsp_clk(dsp_clk),
      .wb_rst (wb_rst),
      .set_i  (set_bus),
      .pps_i  (pps_i),
      .time_o (vita_time)
   );

   ////////////////////////////////////////////////////////////////////
   // Readback and pins
   status_readback status_readback_i (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .rd_stb_i  (rd_stb),
      .rd_sel_i  (rd_sel),
      .irq_i     (irq_i),
      .irq_mask_i(ctrl_regs.irq_mask),
      .time_i    (vita_time),
      .rd_dat_o  (rd_dat),
      .int_o     (int_o)
   );

   ctrl_pins ctrl_pins_i (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .regs_i          (ctrl_regs),
      .clk_status_i    (clk_status_i),
      .serdes_link_up_i(serdes_link_up_i),
      .leds_o          (leds_o),
      .clock_ready_o   (clock_ready_o),
      .clk_en_o        (clk_en_o),
      .clk_sel_o       (clk_sel_o),
      .ser_enable_o    (ser_enable_o),
      .ser_prbsen_o    (ser_prbsen_o),
      .ser_loopen_o    (ser_loopen_o),
      .ser_rx_en_o     (ser_rx_en_o),
      .adc_oe_a_o      (adc_oe_a_o),
      .adc_on_a_o      (adc_on_a_o),
      .adc_oe_b_o      (adc_oe_b_o),
      .adc_on_b_o      (adc_on_b_o),
      .phy_resetn_o    (phy_resetn_o)
   );

endmodule

// File: u2_params.svh
//////////////////////////////////////////////////////////////////////
// Shared constants for the control core
// Address windows, setting addresses, readback indices and widths
//////////////////////////////////////////////////////////////////////
`ifndef U2_PARAMS_SVH
`define U2_PARAMS_SVH

// Bus widths
`define U2_DW             32
`define U2_AW             16
`define U2_SET_AW         8

// Address windows, matched on bits 15:10
`define U2_SETTINGS_BASE  16'hD400
`define U2_READBACK_BASE  16'hCC00

// Setting register addresses
`define U2_SR_CLOCK       0
`define U2_SR_SERDES      1
`define U2_SR_ADC         2
`define U2_SR_LED_SW      3
`define U2_SR_PHY         4
`define U2_SR_LED_SRC     8
`define U2_SR_IRQ_MASK    9
// Time block base, secs then ticks then immediate flag
`define U2_SR_TIME64      192

// Readback word indices
`define U2_RB_SECS        0
`define U2_RB_TICKS       1
`define U2_RB_IRQ         2
`define U2_RB_IRQ_PRIO    3
`define U2_RB_CYCLES      4

`define U2_TICKS_PER_SEC  100000000
`define U2_NIRQ           16

`endif

// File: u2_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types shared by the control core stages
// Bus request, settings strobe, control settings and VITA time
//////////////////////////////////////////////////////////////////////
`include "u2_params.svh"

package u2_pkg;

   typedef logic [`U2_DW-1:0]     wb_word_t;
   typedef logic [`U2_AW-1:0]     wb_addr_t;
   typedef logic [`U2_SET_AW-1:0] set_addr_t;
   typedef logic [`U2_NIRQ-1:0]   irq_vec_t;

   // Request from the bus master
   typedef struct packed {
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_word_t dat;
   } wb_req_t;

   // One setting write
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      wb_word_t  data;
   } set_bus_t;

   // Stored control settings
   typedef struct packed {
      logic [7:0] clock_outs;
      logic [7:0] serdes_outs;
      logic [7:0] adc_outs;
      logic [7:0] led_sw;
      logic [7:0] led_src;
      logic       phy_reset;
      irq_vec_t   irq_mask;
   } ctrl_regs_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   // Time load machine
   typedef enum logic {
      TIME_IDLE,
      TIME_ARMED
   } time_set_e;

endpackage

// File: vita_time_64.sv
//////////////////////////////////////////////////////////////////////
// VITA time keeper with 32 bit seconds and ticks
// Time loads right away or on the next PPS rising edge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "u2_params.svh"

module vita_time_64 (
   input  logic               dsp_clk,
   input  logic               wb_rst,
   input  u2_pkg::set_bus_t   set_i,
   input  logic               pps_i,
   output u2_pkg::vita_time_t time_o
);
   import u2_pkg::*;

   localparam set_addr_t   SR_SECS   = `U2_SR_TIME64;
   localparam set_addr_t   SR_TICKS  = `U2_SR_TIME64 + 1;
   localparam set_addr_t   SR_IMM    = `U2_SR_TIME64 + 2;
   localparam logic [31:0] TICKS_MAX = `U2_TICKS_PER_SEC - 1;

   time_set_e   state;
   vita_time_t  time_q;
   logic [31:0] secs_pend;
   logic [31:0] ticks_pend;
   logic        imm_q;
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_d;
   logic        pps_rise;
   logic        ticks_wr;

   assign ticks_wr = set_i.stb && (set_i.addr == SR_TICKS);
   assign pps_rise = pps_sync & ~pps_d;

   ////////////////////////////////////////////////////////////////////
   // PPS synchronizer and edge detect
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_d    <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_d    <= pps_sync;
      end
   end

   // Pending load values
   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && set_i.addr == SR_SECS)
         secs_pend <= set_i.data;
      if (ticks_wr)
         ticks_pend <= set_i.data;
   end

   ////////////////////////////////////////////////////////////////////
   // Load machine and free running counter
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state  <= TIME_IDLE;
         time_q <= '0;
         imm_q  <= 1'b0;
      end else begin
         if (set_i.stb && set_i.addr == SR_IMM)
            imm_q <= set_i.data[0];
         if (ticks_wr && imm_q) begin
            // Immediate set uses the ticks word on the bus
            time_q <= '{secs: secs_pend, ticks: set_i.data};
            state  <= TIME_IDLE;
         end else if (state == TIME_ARMED && pps_rise) begin
            time_q <= '{secs: secs_pend, ticks: ticks_pend};
            state  <= TIME_IDLE;
         end else begin
            if (ticks_wr)
               state <= TIME_ARMED;
            // Ticks wrap once per second
            if (time_q.ticks == TICKS_MAX) begin
               time_q.ticks <= '0;
               time_q.secs  <= time_q.secs + 1'b1;
            end else begin
               time_q.ticks <= time_q.ticks + 1'b1;
            end
         end
      end
   end

   assign time_o = time_q;

   // Ticks stay inside one second
   a_ticks_range : assert property (@(posedge dsp_clk) disable iff (wb_rst)
      time_o.ticks < 32'(`U2_TICKS_PER_SEC));

endmodule
